// ==== compile.f ====
pixel_pkg.sv
geometry_pkg.sv
bayer_crop.sv
debayer_binning.sv
color_metering.sv
camera_pipeline.sv
camera_pipeline_assertions.sv
camera_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: camera_pipeline

sources:
  - pixel_pkg.sv
  - geometry_pkg.sv
  - bayer_crop.sv
  - debayer_binning.sv
  - color_metering.sv
  - camera_pipeline.sv
  - target: simulation
    files:
      - camera_pipeline_assertions.sv
      - camera_pipeline_tb.sv

// ==== camera_pipeline_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module camera_pipeline_tb;

    import pixel_pkg::*;

    localparam int CLOCK_PERIOD          = 100;
    localparam int CROP_X_START          = 10;
    localparam int CROP_Y_START          = 12;
    localparam int CROP_WIDTH            = 16;
    localparam int CROP_HEIGHT           = 16;
    localparam int CENTER_WINDOW_SIZE    = 4;
    localparam int CENTER_WINDOW_OFFSET  = 2;
    localparam int AVERAGE_WINDOW_SIZE   = 8;
    localparam int AVERAGE_WINDOW_OFFSET = 0;
    localparam int FRAME_COLUMNS         = 32; // Wide enough for the pan window
    localparam int FRAME_LINES           = 32;
    localparam int NUM_FRAMES            = 4;
    localparam int MAX_GAP               = 4;
    localparam int QUADS_PER_FRAME       = (CROP_WIDTH / 2) * (CROP_HEIGHT / 2);
    localparam int FRAME_CYCLES          = FRAME_LINES * (FRAME_COLUMNS + MAX_GAP) + 3 * MAX_GAP;
    localparam int TIMEOUT_CYCLES        = NUM_FRAMES * FRAME_CYCLES + 200;

    logic         mipi_byte_clock = 1'b0;
    logic         mipi_byte_reset_n;
    logic         frame_valid_i;
    logic         line_valid_i;
    bayer_pixel_t bayer_data_i;
    logic         rgb_valid_o;
    logic         frame_valid_o;
    channel_t     red_o;
    channel_t     green_o;
    channel_t     blue_o;
    metering_t    center_red_o;
    metering_t    center_green_o;
    metering_t    center_blue_o;
    logic         center_ready_o;
    metering_t    average_red_o;
    metering_t    average_green_o;
    metering_t    average_blue_o;
    logic         average_ready_o;

    bayer_pixel_t                  raw_frame [FRAME_LINES][FRAME_COLUMNS];
    logic [3*RAW_WIDTH-1:0]        rgb_queue [$];
    int unsigned                   time_queue [$]; // Input cycle of each quad's last sample
    logic [3*METERING_WIDTH-1:0]   center_queue [$];
    logic [3*METERING_WIDTH-1:0]   average_queue [$];
    logic [3*RAW_WIDTH-1:0]        expected_rgb;
    logic [3*METERING_WIDTH-1:0]   expected_metering;
    int unsigned                   expected_cycle;
    logic [1:0]                    frame_valid_history = '0; // Input frame valid, last two cycles
    int unsigned                   cycle_count = 0;
    int                            pixel_count = 0;
    int                            center_frames = 0;
    int                            average_frames = 0;
    int                            check_count = 0;
    int                            error_count = 0;

    camera_pipeline #(
        .CROP_X_START          (CROP_X_START),
        .CROP_Y_START          (CROP_Y_START),
        .CROP_WIDTH            (CROP_WIDTH),
        .CROP_HEIGHT           (CROP_HEIGHT),
        .CENTER_WINDOW_SIZE    (CENTER_WINDOW_SIZE),
        .CENTER_WINDOW_OFFSET  (CENTER_WINDOW_OFFSET),
        .AVERAGE_WINDOW_SIZE   (AVERAGE_WINDOW_SIZE),
        .AVERAGE_WINDOW_OFFSET (AVERAGE_WINDOW_OFFSET)
    ) dut (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_i),
        .line_valid_i      (line_valid_i),
        .bayer_data_i      (bayer_data_i),
        .rgb_valid_o       (rgb_valid_o),
        .frame_valid_o     (frame_valid_o),
        .red_o             (red_o),
        .green_o           (green_o),
        .blue_o            (blue_o),
        .center_red_o      (center_red_o),
        .center_green_o    (center_green_o),
        .center_blue_o     (center_blue_o),
        .center_ready_o    (center_ready_o),
        .average_red_o     (average_red_o),
        .average_green_o   (average_green_o),
        .average_blue_o    (average_blue_o),
        .average_ready_o   (average_ready_o)
    );

    always #(CLOCK_PERIOD / 2) mipi_byte_clock = ~mipi_byte_clock;

    always @(posedge mipi_byte_clock) begin
        cycle_count         <= cycle_count + 1;
        frame_valid_history <= {frame_valid_history[0], frame_valid_i};
    end

    // RGGB quad (qx, qy) of the pan window, packed as red, green, blue
    function automatic logic [3*RAW_WIDTH-1:0] reference_rgb(input int qx, input int qy);
        int x0;
        int y0;
        int green;
        x0    = CROP_X_START + 2 * qx;
        y0    = CROP_Y_START + 2 * qy;
        green = (int'(raw_frame[y0][x0+1]) + int'(raw_frame[y0+1][x0])) / 2;
        return {raw_frame[y0][x0], channel_t'(green), raw_frame[y0+1][x0+1]};
    endfunction

    // Window mean of each channel, top 8 of 10 bits
    function automatic logic [3*METERING_WIDTH-1:0] reference_metering(input int size,
                                                                       input int offset);
        int                     red_total;
        int                     green_total;
        int                     blue_total;
        logic [3*RAW_WIDTH-1:0] rgb;
        red_total   = 0;
        green_total = 0;
        blue_total  = 0;
        for (int qy = offset; qy < offset + size; qy++) begin
            for (int qx = offset; qx < offset + size; qx++) begin
                rgb          = reference_rgb(qx, qy);
                red_total   += int'(rgb[3*RAW_WIDTH-1 -: RAW_WIDTH]);
                green_total += int'(rgb[2*RAW_WIDTH-1 -: RAW_WIDTH]);
                blue_total  += int'(rgb[RAW_WIDTH-1:0]);
            end
        end
        return {metering_t'((red_total / (size * size)) >> 2),
                metering_t'((green_total / (size * size)) >> 2),
                metering_t'((blue_total / (size * size)) >> 2)};
    endfunction

    function automatic logic closes_quad(input int x, input int y);
        return (x >= CROP_X_START) && (x < CROP_X_START + CROP_WIDTH) &&
               (y >= CROP_Y_START) && (y < CROP_Y_START + CROP_HEIGHT) &&
               ((x - CROP_X_START) % 2 == 1) && ((y - CROP_Y_START) % 2 == 1);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic hold_idle(input int cycles, input logic frame_level);
        repeat (cycles) begin
            @(posedge mipi_byte_clock);
            frame_valid_i <= frame_level;
            line_valid_i  <= 1'b0;
            bayer_data_i  <= '0;
        end
    endtask

    task automatic check_reset_state();
        repeat (3) begin
            @(negedge mipi_byte_clock);
            compare_value("rgb_valid_o", 0, rgb_valid_o);
            compare_value("frame_valid_o", 0, frame_valid_o);
            compare_value("center_ready_o", 0, center_ready_o);
            compare_value("average_ready_o", 0, average_ready_o);
            compare_value("center_red_o", 0, center_red_o);
            compare_value("average_blue_o", 0, average_blue_o);
        end
    endtask

    // Fresh random frame, expected results queued before it is sent
    task automatic generate_frame();
        for (int y = 0; y < FRAME_LINES; y++) begin
            for (int x = 0; x < FRAME_COLUMNS; x++) begin
                raw_frame[y][x] = bayer_pixel_t'($urandom);
            end
        end
        for (int qy = 0; qy < CROP_HEIGHT / 2; qy++) begin
            for (int qx = 0; qx < CROP_WIDTH / 2; qx++) begin
                rgb_queue.push_back(reference_rgb(qx, qy));
            end
        end
        center_queue.push_back(reference_metering(CENTER_WINDOW_SIZE, CENTER_WINDOW_OFFSET));
        average_queue.push_back(reference_metering(AVERAGE_WINDOW_SIZE, AVERAGE_WINDOW_OFFSET));
    endtask

    task automatic drive_frame();
        hold_idle(2 + $urandom_range(MAX_GAP - 2), 1'b1); // Frame opens before first line
        for (int y = 0; y < FRAME_LINES; y++) begin
            for (int x = 0; x < FRAME_COLUMNS; x++) begin
                @(posedge mipi_byte_clock);
                frame_valid_i <= 1'b1;
                line_valid_i  <= 1'b1;
                bayer_data_i  <= raw_frame[y][x];
                if (closes_quad(x, y)) begin
                    time_queue.push_back(cycle_count + 1); // Cycle the sample sits on the input
                end
            end
            hold_idle(2 + $urandom_range(MAX_GAP - 2), 1'b1);
        end
        hold_idle(2 + $urandom_range(MAX_GAP - 2), 1'b0); // Gap between frames
    endtask

    always @(negedge mipi_byte_clock) begin
        if (mipi_byte_reset_n) begin
            compare_value("frame_valid_o", frame_valid_history[1], frame_valid_o);
            if (rgb_valid_o) begin
                if (rgb_queue.size() == 0 || time_queue.size() == 0) begin
                    error_count++;
                    $display("An RGB pixel arrived when none was expected");
                end else begin
                    expected_rgb   = rgb_queue.pop_front();
                    expected_cycle = time_queue.pop_front();
                    compare_value("red_o", expected_rgb[3*RAW_WIDTH-1 -: RAW_WIDTH], red_o);
                    compare_value("green_o", expected_rgb[2*RAW_WIDTH-1 -: RAW_WIDTH], green_o);
                    compare_value("blue_o", expected_rgb[RAW_WIDTH-1:0], blue_o);
                    compare_value("rgb_valid_o cycle", expected_cycle + 2, cycle_count);
                end
                pixel_count++;
            end
            if (center_ready_o) begin
                compare_value("rgb_valid_o pulses", QUADS_PER_FRAME, pixel_count);
                pixel_count = 0;
                center_frames++;
                if (center_queue.size() == 0) begin
                    error_count++;
                    $display("center_ready_o pulsed with no frame result expected");
                end else begin
                    expected_metering = center_queue.pop_front();
                    compare_value("center_red_o", expected_metering[23:16], center_red_o);
                    compare_value("center_green_o", expected_metering[15:8], center_green_o);
                    compare_value("center_blue_o", expected_metering[7:0], center_blue_o);
                end
            end
            if (average_ready_o) begin
                average_frames++;
                if (average_queue.size() == 0) begin
                    error_count++;
                    $display("average_ready_o pulsed with no frame result expected");
                end else begin
                    expected_metering = average_queue.pop_front();
                    compare_value("average_red_o", expected_metering[23:16], average_red_o);
                    compare_value("average_green_o", expected_metering[15:8], average_green_o);
                    compare_value("average_blue_o", expected_metering[7:0], average_blue_o);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the frames did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(28));
        mipi_byte_reset_n = 1'b0;
        frame_valid_i     = 1'b0;
        line_valid_i      = 1'b0;
        bayer_data_i      = '0;
        repeat (3) @(posedge mipi_byte_clock);
        mipi_byte_reset_n <= 1'b1;
        check_reset_state();
        for (int frame = 0; frame < NUM_FRAMES; frame++) begin
            generate_frame();
            drive_frame();
        end
        wait (center_frames == NUM_FRAMES && average_frames == NUM_FRAMES);
        repeat (8) @(negedge mipi_byte_clock); // Catch any late extra pulses
        compare_value("center_ready_o pulses", NUM_FRAMES, center_frames);
        compare_value("average_ready_o pulses", NUM_FRAMES, average_frames);
        if (rgb_queue.size() != 0 || center_queue.size() != 0 || average_queue.size() != 0) begin
            error_count++;
            $display("Some expected results never came out of the pipeline");
        end
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut.protocol_checks.failure_count);
        if (error_count == 0 && dut.protocol_checks.failure_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== camera_pipeline_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module camera_pipeline_assertions (
    input logic                     mipi_byte_clock,
    input logic                     mipi_byte_reset_n,
    input logic                     rgb_valid_i,
    input logic                     frame_valid_i,
    input logic                     center_ready_i,
    input logic                     average_ready_i,
    input logic                     cropped_frame_valid_i,
    input geometry_pkg::row_phase_t row_phase_i
);

    import geometry_pkg::*;

    int failure_count = 0; // Failed assertion tally

    rgb_inside_frame: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        rgb_valid_i |-> frame_valid_i)
    else begin
        $error("rgb_valid_o high while frame_valid_o is low");
        failure_count++;
    end

    center_ready_single: assert property (@(posedge mipi_byte_clock)
        disable iff (!mipi_byte_reset_n) center_ready_i |=> !center_ready_i)
    else begin
        $error("center_ready_o lasted more than one cycle");
        failure_count++;
    end

    average_ready_single: assert property (@(posedge mipi_byte_clock)
        disable iff (!mipi_byte_reset_n) average_ready_i |=> !average_ready_i)
    else begin
        $error("average_ready_o lasted more than one cycle");
        failure_count++;
    end

    // Row toggling is back on the R G row by the time a new frame starts
    phase_at_frame_start: assert property (@(posedge mipi_byte_clock)
        disable iff (!mipi_byte_reset_n) $rose(cropped_frame_valid_i) |-> row_phase_i == even_row)
    else begin
        $error("Debayer row phase not even_row at frame start");
        failure_count++;
    end

endmodule

bind camera_pipeline camera_pipeline_assertions protocol_checks (
    .mipi_byte_clock       (mipi_byte_clock),
    .mipi_byte_reset_n     (mipi_byte_reset_n),
    .rgb_valid_i           (rgb_valid_o),
    .frame_valid_i         (frame_valid_o),
    .center_ready_i        (center_ready_o),
    .average_ready_i       (average_ready_o),
    .cropped_frame_valid_i (cropped_frame_valid),
    .row_phase_i           (debayer.row_phase)
);

`default_nettype wire

// ==== camera_pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module camera_pipeline #(
    parameter int CROP_X_START          = 10,
    parameter int CROP_Y_START          = 12,
    parameter int CROP_WIDTH            = 16, // Must be even
    parameter int CROP_HEIGHT           = 16, // Must be even
    parameter int CENTER_WINDOW_SIZE    = 4,
    parameter int CENTER_WINDOW_OFFSET  = 2,
    parameter int AVERAGE_WINDOW_SIZE   = 8,  // Whole debayered image
    parameter int AVERAGE_WINDOW_OFFSET = 0
) (
    input  logic                    mipi_byte_clock,
    input  logic                    mipi_byte_reset_n,
    input  logic                    frame_valid_i,
    input  logic                    line_valid_i,
    input  pixel_pkg::bayer_pixel_t bayer_data_i,
    output logic                    rgb_valid_o,
    output logic                    frame_valid_o,
    output pixel_pkg::channel_t     red_o,
    output pixel_pkg::channel_t     green_o,
    output pixel_pkg::channel_t     blue_o,
    output pixel_pkg::metering_t    center_red_o,
    output pixel_pkg::metering_t    center_green_o,
    output pixel_pkg::metering_t    center_blue_o,
    output logic                    center_ready_o,
    output pixel_pkg::metering_t    average_red_o,
    output pixel_pkg::metering_t    average_green_o,
    output pixel_pkg::metering_t    average_blue_o,
    output logic                    average_ready_o
);

    import pixel_pkg::*;

    localparam int IMAGE_WIDTH = CROP_WIDTH / 2; // One RGB pixel per quad

    logic         cropped_frame_valid;
    logic         cropped_line_valid;
    bayer_pixel_t cropped_data;

    bayer_crop #(
        .CROP_X_START (CROP_X_START),
        .CROP_Y_START (CROP_Y_START),
        .CROP_WIDTH   (CROP_WIDTH),
        .CROP_HEIGHT  (CROP_HEIGHT)
    ) pan_crop (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_i),
        .line_valid_i      (line_valid_i),
        .bayer_data_i      (bayer_data_i),
        .frame_valid_o     (cropped_frame_valid),
        .line_valid_o      (cropped_line_valid),
        .bayer_data_o      (cropped_data)
    );

    debayer_binning #(
        .MAX_LINE_WIDTH (IMAGE_WIDTH)
    ) debayer (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (cropped_frame_valid),
        .line_valid_i      (cropped_line_valid),
        .bayer_data_i      (cropped_data),
        .frame_valid_o     (frame_valid_o), // Debayered frame valid
        .rgb_valid_o       (rgb_valid_o),
        .red_o             (red_o),
        .green_o           (green_o),
        .blue_o            (blue_o)
    );

    color_metering #(
        .IMAGE_WIDTH   (IMAGE_WIDTH),
        .WINDOW_SIZE   (CENTER_WINDOW_SIZE),
        .WINDOW_OFFSET (CENTER_WINDOW_OFFSET)
    ) center_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_o),
        .rgb_valid_i       (rgb_valid_o),
        .red_i             (red_o),
        .green_i           (green_o),
        .blue_i            (blue_o),
        .red_o             (center_red_o),
        .green_o           (center_green_o),
        .blue_o            (center_blue_o),
        .metering_ready_o  (center_ready_o)
    );

    color_metering #(
        .IMAGE_WIDTH   (IMAGE_WIDTH),
        .WINDOW_SIZE   (AVERAGE_WINDOW_SIZE),
        .WINDOW_OFFSET (AVERAGE_WINDOW_OFFSET)
    ) average_metering (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_o),
        .rgb_valid_i       (rgb_valid_o),
        .red_i             (red_o),
        .green_i           (green_o),
        .blue_i            (blue_o),
        .red_o             (average_red_o),
        .green_o           (average_green_o),
        .blue_o            (average_blue_o),
        .metering_ready_o  (average_ready_o)
    );

endmodule

`default_nettype wire

// ==== color_metering.sv ====
`timescale 1ns/10ps
`default_nettype none

module color_metering #(
    parameter int IMAGE_WIDTH   = 8,
    parameter int WINDOW_SIZE   = 4,
    parameter int WINDOW_OFFSET = 2
) (
    input  logic                 mipi_byte_clock,
    input  logic                 mipi_byte_reset_n,
    input  logic                 frame_valid_i,
    input  logic                 rgb_valid_i,
    input  pixel_pkg::channel_t  red_i,
    input  pixel_pkg::channel_t  green_i,
    input  pixel_pkg::channel_t  blue_i,
    output pixel_pkg::metering_t red_o,
    output pixel_pkg::metering_t green_o,
    output pixel_pkg::metering_t blue_o,
    output logic                 metering_ready_o
);

    import pixel_pkg::*;
    import geometry_pkg::*;

    localparam int     SHIFT        = 2 * $clog2(WINDOW_SIZE); // Divide by pixel count
    localparam int     ACC_WIDTH    = RAW_WIDTH + SHIFT;
    localparam coord_t WINDOW_FIRST = coord_t'(WINDOW_OFFSET);
    localparam coord_t WINDOW_END   = coord_t'(WINDOW_OFFSET + WINDOW_SIZE);
    localparam coord_t LAST_COLUMN  = coord_t'(IMAGE_WIDTH - 1);

    coord_t               column_count;
    coord_t               row_count;
    logic                 frame_valid_q;
    logic                 frame_start;
    logic                 frame_end;
    logic                 in_window;
    logic [ACC_WIDTH-1:0] red_sum;
    logic [ACC_WIDTH-1:0] green_sum;
    logic [ACC_WIDTH-1:0] blue_sum;

    assign frame_start = frame_valid_i & ~frame_valid_q;
    assign frame_end   = ~frame_valid_i & frame_valid_q;
    assign in_window   = (column_count >= WINDOW_FIRST) && (column_count < WINDOW_END) &&
                         (row_count >= WINDOW_FIRST) && (row_count < WINDOW_END);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            column_count  <= '0;
            row_count     <= '0;
            red_sum       <= '0;
            green_sum     <= '0;
            blue_sum      <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            if (frame_start) begin // Fresh sums for every frame
                column_count <= '0;
                row_count    <= '0;
                red_sum      <= '0;
                green_sum    <= '0;
                blue_sum     <= '0;
            end else if (rgb_valid_i) begin
                if (column_count == LAST_COLUMN) begin
                    column_count <= '0;
                    row_count    <= coord_t'(row_count + 1'b1);
                end else begin
                    column_count <= coord_t'(column_count + 1'b1);
                end
                if (in_window) begin
                    red_sum   <= red_sum + ACC_WIDTH'(red_i);
                    green_sum <= green_sum + ACC_WIDTH'(green_i);
                    blue_sum  <= blue_sum + ACC_WIDTH'(blue_i);
                end
            end
        end
    end

    // Average is sum[ACC_WIDTH-1:SHIFT], report its top bits
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            red_o            <= '0;
            green_o          <= '0;
            blue_o           <= '0;
            metering_ready_o <= 1'b0;
        end else begin
            metering_ready_o <= frame_end;
            if (frame_end) begin
                red_o   <= red_sum[ACC_WIDTH-1 -: METERING_WIDTH];
                green_o <= green_sum[ACC_WIDTH-1 -: METERING_WIDTH];
                blue_o  <= blue_sum[ACC_WIDTH-1 -: METERING_WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

// ==== debayer_binning.sv ====
`timescale 1ns/10ps
`default_nettype none

module debayer_binning #(
    parameter int MAX_LINE_WIDTH = 8 // Quads per cropped line
) (
    input  logic                    mipi_byte_clock,
    input  logic                    mipi_byte_reset_n,
    input  logic                    frame_valid_i,
    input  logic                    line_valid_i,
    input  pixel_pkg::bayer_pixel_t bayer_data_i,
    output logic                    frame_valid_o,
    output logic                    rgb_valid_o,
    output pixel_pkg::channel_t     red_o,
    output pixel_pkg::channel_t     green_o,
    output pixel_pkg::channel_t     blue_o
);

    import pixel_pkg::*;
    import geometry_pkg::*;

    localparam int ADDR_WIDTH = (MAX_LINE_WIDTH > 1) ? $clog2(MAX_LINE_WIDTH) : 1;

    bayer_pixel_t          red_buffer [MAX_LINE_WIDTH];   // Even row, even columns
    bayer_pixel_t          green_buffer [MAX_LINE_WIDTH]; // Even row, odd columns
    row_phase_t            row_phase;
    coord_t                column_count;
    logic [ADDR_WIDTH-1:0] quad_index;
    bayer_pixel_t          previous_sample;               // Bottom left green of the quad
    logic                  frame_valid_q;
    logic                  line_valid_q;
    logic                  frame_start;
    logic                  line_end;
    logic                  odd_column;
    logic                  quad_done;
    logic [RAW_WIDTH:0]    green_sum;

    assign frame_start = frame_valid_i & ~frame_valid_q;
    assign line_end    = line_valid_q & ~line_valid_i;
    assign quad_index  = column_count[ADDR_WIDTH:1];
    assign odd_column  = column_count[0];
    assign quad_done   = line_valid_i & (row_phase == odd_row) & odd_column;
    assign green_sum   = {1'b0, green_buffer[quad_index]} + {1'b0, previous_sample};

    // Half-line buffers
    always_ff @(posedge mipi_byte_clock) begin
        if (line_valid_i && row_phase == even_row) begin
            if (odd_column) begin
                green_buffer[quad_index] <= bayer_data_i;
            end else begin
                red_buffer[quad_index] <= bayer_data_i;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q   <= 1'b0;
            line_valid_q    <= 1'b0;
            row_phase       <= even_row;
            column_count    <= '0;
            previous_sample <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q  <= line_valid_i;

            if (frame_start) begin
                row_phase <= even_row;
            end else if (line_end) begin
                case (row_phase)
                    even_row: row_phase <= odd_row;
                    odd_row:  row_phase <= even_row;
                    default:  row_phase <= even_row;
                endcase
            end

            if (line_end) begin
                column_count <= '0;
            end else if (line_valid_i) begin
                column_count <= coord_t'(column_count + 1'b1);
            end

            if (line_valid_i && row_phase == odd_row) begin
                previous_sample <= bayer_data_i;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_o <= 1'b0;
            rgb_valid_o   <= 1'b0;
            red_o         <= '0;
            green_o       <= '0;
            blue_o        <= '0;
        end else begin
            frame_valid_o <= frame_valid_i;
            rgb_valid_o   <= quad_done;
            if (quad_done) begin
                red_o   <= red_buffer[quad_index];
                green_o <= green_sum[RAW_WIDTH:1]; // Mean of both greens, truncated
                blue_o  <= bayer_data_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bayer_crop.sv ====
`timescale 1ns/10ps
`default_nettype none

module bayer_crop #(
    parameter int CROP_X_START = 10,
    parameter int CROP_Y_START = 12,
    parameter int CROP_WIDTH   = 16,
    parameter int CROP_HEIGHT  = 16
) (
    input  logic                    mipi_byte_clock,
    input  logic                    mipi_byte_reset_n,
    input  logic                    frame_valid_i,
    input  logic                    line_valid_i,
    input  pixel_pkg::bayer_pixel_t bayer_data_i,
    output logic                    frame_valid_o,
    output logic                    line_valid_o,
    output pixel_pkg::bayer_pixel_t bayer_data_o
);

    import geometry_pkg::*;

    localparam coord_t X_FIRST = coord_t'(CROP_X_START);
    localparam coord_t X_END   = coord_t'(CROP_X_START + CROP_WIDTH);  // One past last column
    localparam coord_t Y_FIRST = coord_t'(CROP_Y_START);
    localparam coord_t Y_END   = coord_t'(CROP_Y_START + CROP_HEIGHT); // One past last line

    coord_t column_count;
    coord_t line_count;
    coord_t line_now;
    logic   frame_valid_q;
    logic   line_valid_q;
    logic   frame_start;
    logic   line_end;
    logic   in_window;

    assign frame_start = frame_valid_i & ~frame_valid_q;
    assign line_end    = line_valid_q & ~line_valid_i;
    assign line_now    = frame_start ? '0 : line_count; // First line may start with the frame

    assign in_window = (column_count >= X_FIRST) && (column_count < X_END) &&
                       (line_now >= Y_FIRST) && (line_now < Y_END);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            column_count  <= '0;
            line_count    <= '0;
            frame_valid_o <= 1'b0;
            line_valid_o  <= 1'b0;
            bayer_data_o  <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q  <= line_valid_i;

            if (line_end) begin
                column_count <= '0;
            end else if (line_valid_i) begin
                column_count <= coord_t'(column_count + 1'b1);
            end

            if (frame_start) begin
                line_count <= '0;
            end else if (line_end) begin
                line_count <= coord_t'(line_count + 1'b1);
            end

            frame_valid_o <= frame_valid_i;
            line_valid_o  <= line_valid_i & frame_valid_i & in_window; // Only pan window pixels
            bayer_data_o  <= bayer_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== geometry_pkg.sv ====
`default_nettype none

package geometry_pkg;

    localparam int COORD_WIDTH = 11; // Enough for a 2047 pixel line

    typedef logic [COORD_WIDTH-1:0] coord_t; // Column or line position

    // Bayer row parity inside the cropped frame
    typedef enum logic {
        even_row = 1'b0, // R G row, stored in the line buffer
        odd_row  = 1'b1  // G B row, completes the quads
    } row_phase_t;

endpackage

`default_nettype wire

// ==== pixel_pkg.sv ====
`default_nettype none

package pixel_pkg;

    localparam int RAW_WIDTH      = 10; // Sensor sample width
    localparam int METERING_WIDTH = 8;  // Reported average width

    // One raw RGGB sample from the sensor bridge
    typedef logic [RAW_WIDTH-1:0] bayer_pixel_t;

    // One debayered colour channel, same range as raw
    typedef logic [RAW_WIDTH-1:0] channel_t;

    // Upper bits of a channel average
    typedef logic [METERING_WIDTH-1:0] metering_t;

endpackage

`default_nettype wire
